// ==== all.f ====
isa_pkg.sv
pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
memory_stage.sv
hazard_ctrl.sv
core_top.sv
core_tb_assert.sv
core_tb.sv

// ==== Bender.yml ====
package:
  name: mips_pipe

sources:
  - isa_pkg.sv
  - pipe_pkg.sv
  - fetch_stage.sv
  - decode_stage.sv
  - reg_file.sv
  - execute_stage.sv
  - memory_stage.sv
  - hazard_ctrl.sv
  - core_top.sv
  - target: test
    files:
      - core_tb_assert.sv
      - core_tb.sv

// ==== core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_tb;

    localparam isa_pkg::word_t reset_pc = 32'h0040_0000;

    logic                 clk = 1'b0;
    logic                 reset = 1'b1;
    pipe_pkg::ibus_req_t  ibus_req;
    pipe_pkg::ibus_resp_t ibus_resp = '0;
    pipe_pkg::dbus_req_t  dbus_req;
    pipe_pkg::dbus_resp_t dbus_resp = '0;

    isa_pkg::word_t      imem [64];
    isa_pkg::word_t      dmem [64];
    isa_pkg::word_t      prog [$];
    pipe_pkg::dbus_req_t seen_stores [$];
    pipe_pkg::dbus_req_t exp_stores [$];
    integer              seed = 15;
    int                  max_wait = 0;
    int                  iwait = 0;
    int                  dwait = 0;

    core_top #(
        .reset_pc(reset_pc)
    ) u_core_top (
        .clk,
        .reset,
        .ibus_req,
        .ibus_resp,
        .dbus_req,
        .dbus_resp
    );

    always #20 clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input isa_pkg::word_t got,
                              input isa_pkg::word_t exp);
        if (got !== exp) begin
            report_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_dbus_req(input string name, input pipe_pkg::dbus_req_t got,
                                  input pipe_pkg::dbus_req_t exp);
        if (got !== exp) begin
            report_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic int next_delay();
        return $unsigned($random(seed)) % (max_wait + 1);
    endfunction

    // every index bit shows up in the word
    function automatic isa_pkg::word_t fill_word(input int idx);
        return (idx * 32'h9E37_79B9) ^ 32'h1357_0000;
    endfunction

    function automatic isa_pkg::word_t fetch_word(input isa_pkg::word_t addr);
        isa_pkg::word_t off;
        off = addr - reset_pc;
        if (off < 32'd256) begin
            return imem[off[7:2]];
        end
        return '0;
    endfunction

    function automatic isa_pkg::word_t r_word(input isa_pkg::funct_t fn,
                                              input isa_pkg::reg_addr_t rd,
                                              input isa_pkg::reg_addr_t rs,
                                              input isa_pkg::reg_addr_t rt);
        isa_pkg::instr_u w;
        w.r.opcode = isa_pkg::OP_SPECIAL;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = '0;
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic isa_pkg::word_t i_word(input isa_pkg::opcode_t op,
                                              input isa_pkg::reg_addr_t rt,
                                              input isa_pkg::reg_addr_t rs,
                                              input logic [15:0] imm);
        isa_pkg::instr_u w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    // instruction memory, answers after a random number of wait cycles
    always @(posedge clk) begin
        if (reset) begin
            ibus_resp.ok <= 1'b0;
            iwait <= next_delay();
        end else if (ibus_resp.ok) begin
            ibus_resp.ok <= 1'b0;
        end else if (ibus_req.valid) begin
            if (iwait == 0) begin
                ibus_resp.ok   <= 1'b1;
                ibus_resp.data <= fetch_word(ibus_req.addr);
                iwait <= next_delay();
            end else begin
                iwait <= iwait - 1;
            end
        end
    end

    // data memory, logs every write it accepts
    always @(posedge clk) begin
        if (reset) begin
            dbus_resp.ok <= 1'b0;
            dwait <= next_delay();
        end else if (dbus_resp.ok) begin
            dbus_resp.ok <= 1'b0;
        end else if (dbus_req.valid) begin
            if (dwait == 0) begin
                dbus_resp.ok    <= 1'b1;
                dbus_resp.rdata <= dmem[dbus_req.addr[7:2]];
                if (dbus_req.write) begin
                    dmem[dbus_req.addr[7:2]] = dbus_req.wdata;
                    seen_stores.push_back(dbus_req);
                end
                dwait <= next_delay();
            end else begin
                dwait <= dwait - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (u_core_top.u_core_tb_assert.fail_count != 0) begin
            report_error("a bus handshake assertion fired");
        end
    end

    // plain instruction-set interpreter over prog
    task automatic compute_expected();
        isa_pkg::word_t      regs [32];
        isa_pkg::word_t      mem [64];
        isa_pkg::instr_u     ins;
        isa_pkg::word_t      a;
        isa_pkg::word_t      b;
        isa_pkg::word_t      imm;
        isa_pkg::word_t      addr;
        pipe_pkg::dbus_req_t st;
        int                  pc_idx;
        int                  steps;
        for (int i = 0; i < 64; i++) begin
            mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        exp_stores.delete();
        pc_idx = 0;
        steps  = 0;
        while (pc_idx >= 0 && pc_idx < prog.size() && steps < 500) begin
            ins  = prog[pc_idx];
            a    = regs[ins.i.rs];
            b    = regs[ins.i.rt];
            imm  = {{16{ins.i.imm[15]}}, ins.i.imm};
            addr = a + imm;
            pc_idx++;
            steps++;
            case (ins.i.opcode)
                isa_pkg::OP_SPECIAL: begin
                    case (ins.r.funct)
                        isa_pkg::FN_ADDU: regs[ins.r.rd] = a + b;
                        isa_pkg::FN_SUBU: regs[ins.r.rd] = a - b;
                        isa_pkg::FN_AND:  regs[ins.r.rd] = a & b;
                        isa_pkg::FN_OR:   regs[ins.r.rd] = a | b;
                        isa_pkg::FN_XOR:  regs[ins.r.rd] = a ^ b;
                        isa_pkg::FN_SLT:  regs[ins.r.rd] = ($signed(a) < $signed(b)) ? 1 : 0;
                        default: ;
                    endcase
                end
                isa_pkg::OP_ADDIU: regs[ins.i.rt] = a + imm;
                isa_pkg::OP_ORI:   regs[ins.i.rt] = a | {16'h0000, ins.i.imm};
                isa_pkg::OP_LUI:   regs[ins.i.rt] = {ins.i.imm, 16'h0000};
                isa_pkg::OP_LW:    regs[ins.i.rt] = mem[addr[7:2]];
                isa_pkg::OP_SW: begin
                    st.valid = 1'b1;
                    st.write = 1'b1;
                    st.addr  = addr;
                    st.wdata = b;
                    exp_stores.push_back(st);
                    mem[addr[7:2]] = b;
                end
                isa_pkg::OP_BEQ: if (a == b) pc_idx = pc_idx + int'($signed(ins.i.imm));
                isa_pkg::OP_BNE: if (a != b) pc_idx = pc_idx + int'($signed(ins.i.imm));
                default: ;
            endcase
            regs[0] = '0;
        end
    endtask

    task automatic run_program();
        int cycles;
        @(posedge clk);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : '0;
            dmem[i] = fill_word(i);
        end
        compute_expected();
        seen_stores.delete();
        reset <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!ibus_req.valid) begin
            cycles++;
            if (cycles > 20) begin
                report_error("no instruction request after reset");
            end
            @(negedge clk);
        end
        check_word("ibus_req.addr", ibus_req.addr, reset_pc);
        cycles = 0;
        while (seen_stores.size() < exp_stores.size()) begin
            cycles++;
            if (cycles > 1000) begin
                report_error("timed out waiting for the program's stores");
            end
            @(negedge clk);
        end
        // let the pipe drain so any stray store lands in the log
        repeat (40) @(posedge clk);
        if (seen_stores.size() != exp_stores.size()) begin
            report_error($sformatf("expected %0d stores but the core made %0d",
                                   exp_stores.size(), seen_stores.size()));
        end
        foreach (exp_stores[i]) begin
            check_dbus_req($sformatf("dbus_req[%0d]", i), seen_stores[i], exp_stores[i]);
        end
    endtask

    task automatic load_alu_prog();
        prog.delete();
        prog.push_back(i_word(isa_pkg::OP_LUI, 5'd1, 5'd0, 16'h1234));
        prog.push_back(i_word(isa_pkg::OP_ORI, 5'd1, 5'd1, 16'h5678));
        prog.push_back(i_word(isa_pkg::OP_ADDIU, 5'd2, 5'd0, 16'hfffd));
        prog.push_back(r_word(isa_pkg::FN_ADDU, 5'd3, 5'd1, 5'd2));
        prog.push_back(r_word(isa_pkg::FN_SUBU, 5'd4, 5'd1, 5'd2));
        prog.push_back(r_word(isa_pkg::FN_AND, 5'd5, 5'd1, 5'd2));
        prog.push_back(r_word(isa_pkg::FN_OR, 5'd6, 5'd1, 5'd2));
        prog.push_back(r_word(isa_pkg::FN_XOR, 5'd7, 5'd1, 5'd2));
        prog.push_back(r_word(isa_pkg::FN_SLT, 5'd8, 5'd2, 5'd1));
        prog.push_back(r_word(isa_pkg::FN_SLT, 5'd9, 5'd1, 5'd2));
        prog.push_back(i_word(isa_pkg::OP_ORI, 5'd10, 5'd0, 16'h8001));
        prog.push_back(i_word(isa_pkg::OP_ADDIU, 5'd11, 5'd1, 16'h8000));
        for (int r = 1; r <= 11; r++) begin
            prog.push_back(i_word(isa_pkg::OP_SW, 5'(r), 5'd0, 16'(r * 4)));
        end
    endtask

    task automatic load_fwd_prog();
        prog.delete();
        prog.push_back(i_word(isa_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd5));
        prog.push_back(r_word(isa_pkg::FN_ADDU, 5'd2, 5'd1, 5'd1));
        prog.push_back(r_word(isa_pkg::FN_ADDU, 5'd3, 5'd2, 5'd1));
        prog.push_back(i_word(isa_pkg::OP_SW, 5'd3, 5'd0, 16'h0040));
        prog.push_back(i_word(isa_pkg::OP_LW, 5'd4, 5'd0, 16'h0040));
        prog.push_back(r_word(isa_pkg::FN_ADDU, 5'd5, 5'd4, 5'd3));
        prog.push_back(i_word(isa_pkg::OP_SW, 5'd5, 5'd0, 16'h0044));
        prog.push_back(i_word(isa_pkg::OP_LW, 5'd6, 5'd0, 16'h0010));
        prog.push_back(i_word(isa_pkg::OP_SW, 5'd6, 5'd0, 16'h0048));
        prog.push_back(i_word(isa_pkg::OP_LW, 5'd7, 5'd0, 16'h0014));
        prog.push_back(r_word(isa_pkg::FN_SUBU, 5'd8, 5'd1, 5'd7));
        prog.push_back(i_word(isa_pkg::OP_SW, 5'd8, 5'd0, 16'h004c));
        prog.push_back(i_word(isa_pkg::OP_ADDIU, 5'd9, 5'd0, 16'h0050));
        prog.push_back(i_word(isa_pkg::OP_SW, 5'd8, 5'd9, 16'h0004));
    endtask

    task automatic load_branch_prog();
        prog.delete();
        prog.push_back(i_word(isa_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd7));
        prog.push_back(i_word(isa_pkg::OP_ADDIU, 5'd2, 5'd0, 16'd7));
        prog.push_back(i_word(isa_pkg::OP_BEQ, 5'd2, 5'd1, 16'd2));
        prog.push_back(i_word(isa_pkg::OP_SW, 5'd1, 5'd0, 16'h0080));
        prog.push_back(i_word(isa_pkg::OP_SW, 5'd2, 5'd0, 16'h0084));
        prog.push_back(i_word(isa_pkg::OP_SW, 5'd1, 5'd0, 16'h0088));
        prog.push_back(i_word(isa_pkg::OP_BNE, 5'd2, 5'd1, 16'd2));
        prog.push_back(i_word(isa_pkg::OP_SW, 5'd2, 5'd0, 16'h008c));
        prog.push_back(i_word(isa_pkg::OP_ADDIU, 5'd3, 5'd0, 16'd1));
        prog.push_back(i_word(isa_pkg::OP_BNE, 5'd3, 5'd1, 16'd2));
        prog.push_back(i_word(isa_pkg::OP_SW, 5'd3, 5'd0, 16'h0090));
        prog.push_back(i_word(isa_pkg::OP_SW, 5'd3, 5'd0, 16'h0094));
        prog.push_back(i_word(isa_pkg::OP_BEQ, 5'd3, 5'd1, 16'd1));
        prog.push_back(i_word(isa_pkg::OP_SW, 5'd3, 5'd0, 16'h0098));
    endtask

    task automatic test_alu();
        max_wait = 0;
        load_alu_prog();
        run_program();
    endtask

    task automatic test_forwarding();
        max_wait = 0;
        load_fwd_prog();
        run_program();
    endtask

    task automatic test_branches();
        max_wait = 0;
        load_branch_prog();
        run_program();
    endtask

    // same programs, both buses stretched by 0 to 3 wait cycles
    task automatic test_random_waits();
        max_wait = 3;
        load_alu_prog();
        run_program();
        load_fwd_prog();
        run_program();
        load_branch_prog();
        run_program();
    endtask

    initial begin
        test_alu();
        test_forwarding();
        test_branches();
        test_random_waits();
        if (u_core_top.u_core_tb_assert.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            report_error("a bus handshake assertion fired");
        end
    end

endmodule

`default_nettype wire

// ==== core_tb_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_tb_assert (
    input logic                 clk,
    input logic                 reset,
    input pipe_pkg::ibus_req_t  ibus_req,
    input pipe_pkg::ibus_resp_t ibus_resp,
    input pipe_pkg::dbus_req_t  dbus_req,
    input pipe_pkg::dbus_resp_t dbus_resp
);
    // read by the testbench to end the run
    int fail_count = 0;

    // a request stays put until the bus answers
    ibus_stable: assert property (@(posedge clk) disable iff (reset)
        ibus_req.valid && !ibus_resp.ok |=> $stable(ibus_req))
        else begin
            fail_count++;
            $error("ibus request changed before ok");
        end

    dbus_stable: assert property (@(posedge clk) disable iff (reset)
        dbus_req.valid && !dbus_resp.ok |=> $stable(dbus_req))
        else begin
            fail_count++;
            $error("dbus request changed before ok");
        end

    // no data access while the core sits in reset
    dbus_quiet: assert property (@(posedge clk) reset |=> !dbus_req.valid)
        else begin
            fail_count++;
            $error("dbus valid high during reset");
        end

endmodule

bind core_top core_tb_assert u_core_tb_assert (
    .clk,
    .reset,
    .ibus_req,
    .ibus_resp,
    .dbus_req,
    .dbus_resp
);

`default_nettype wire

// ==== core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_top #(
    parameter isa_pkg::word_t reset_pc = 32'hBFC0_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    output pipe_pkg::ibus_req_t  ibus_req,
    input  pipe_pkg::ibus_resp_t ibus_resp,
    output pipe_pkg::dbus_req_t  dbus_req,
    input  pipe_pkg::dbus_resp_t dbus_resp
);
    pipe_pkg::fd_t      fd;
    pipe_pkg::de_t      de;
    pipe_pkg::em_t      em;
    pipe_pkg::wb_t      wb;
    isa_pkg::reg_addr_t rs_addr;
    isa_pkg::reg_addr_t rt_addr;
    isa_pkg::word_t     rs_data;
    isa_pkg::word_t     rt_data;
    isa_pkg::word_t     redirect_pc;
    logic               redirect;
    logic               hold_front;
    logic               freeze;
    logic               flush_front;
    logic               dbus_busy;

    fetch_stage #(
        .reset_pc(reset_pc)
    ) u_fetch_stage (
        .clk,
        .reset,
        .hold_front,
        .freeze,
        .flush_front,
        .redirect,
        .redirect_pc,
        .ibus_req,
        .ibus_resp,
        .fd
    );

    decode_stage u_decode_stage (
        .clk,
        .reset,
        .hold_front,
        .flush_front,
        .freeze,
        .fd,
        .rs_addr,
        .rt_addr,
        .rs_data,
        .rt_data,
        .de
    );

    reg_file u_reg_file (
        .clk,
        .reset,
        .rs_addr,
        .rt_addr,
        .rs_data,
        .rt_data,
        .wb
    );

    execute_stage u_execute_stage (
        .clk,
        .reset,
        .freeze,
        .de,
        .wb,
        .em,
        .redirect,
        .redirect_pc
    );

    memory_stage u_memory_stage (
        .clk,
        .reset,
        .em,
        .dbus_req,
        .dbus_resp,
        .dbus_busy,
        .wb
    );

    hazard_ctrl u_hazard_ctrl (
        .de,
        .rs_addr,
        .rt_addr,
        .redirect,
        .dbus_busy,
        .hold_front,
        .freeze,
        .flush_front
    );

endmodule

`default_nettype wire

// ==== hazard_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazard_ctrl (
    input  pipe_pkg::de_t      de,
    input  isa_pkg::reg_addr_t rs_addr,
    input  isa_pkg::reg_addr_t rt_addr,
    input  logic               redirect,
    input  logic               dbus_busy,
    output logic               hold_front,
    output logic               freeze,
    output logic               flush_front
);
    logic load_use;

    // load in execute feeding the instruction in decode
    assign load_use = de.valid & de.memread & (de.dest != '0) &
                      ((de.dest == rs_addr) | (de.dest == rt_addr));

    assign freeze      = dbus_busy;
    assign hold_front  = load_use & ~freeze;
    // execute already holds redirect off while frozen
    assign flush_front = redirect;

endmodule

`default_nettype wire

// ==== memory_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module memory_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  pipe_pkg::em_t        em,
    output pipe_pkg::dbus_req_t  dbus_req,
    input  pipe_pkg::dbus_resp_t dbus_resp,
    output logic                 dbus_busy,
    output pipe_pkg::wb_t        wb
);
    logic mem_access;

    assign mem_access = em.valid & (em.memread | em.memwrite);

    // request comes straight from the em register, which freeze keeps still
    assign dbus_req.valid = mem_access;
    assign dbus_req.write = em.memwrite;
    assign dbus_req.addr  = em.result;
    assign dbus_req.wdata = em.store_data;

    assign dbus_busy = mem_access & ~dbus_resp.ok;

    always_ff @(posedge clk) begin
        wb.dest     <= em.dest;
        wb.regwrite <= em.regwrite;
        wb.data     <= em.memread ? dbus_resp.rdata : em.result;
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            // bubble while the data bus is still out
            wb.valid <= em.valid & ~dbus_busy;
        end
    end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic           clk,
    input  logic           reset,
    input  logic           freeze,
    input  pipe_pkg::de_t  de,
    input  pipe_pkg::wb_t  wb,
    output pipe_pkg::em_t  em,
    output logic           redirect,
    output isa_pkg::word_t redirect_pc
);
    isa_pkg::word_t rs_fwd;
    isa_pkg::word_t rt_fwd;
    isa_pkg::word_t rs_keep;
    isa_pkg::word_t rt_keep;
    isa_pkg::word_t op_a;
    isa_pkg::word_t op_b_reg;
    isa_pkg::word_t op_b;
    isa_pkg::word_t alu_out;
    logic           held;
    logic           taken;
    pipe_pkg::em_t  em_next;

    // later match wins, memory stage is the youngest producer
    function automatic isa_pkg::word_t forward(input isa_pkg::reg_addr_t r,
                                               input isa_pkg::word_t v,
                                               input pipe_pkg::em_t m,
                                               input pipe_pkg::wb_t w);
        forward = v;
        if (r != '0 && w.valid && w.regwrite && w.dest == r) begin
            forward = w.data;
        end
        if (r != '0 && m.valid && m.regwrite && m.dest == r) begin
            forward = m.result;
        end
    endfunction

    assign rs_fwd = forward(de.rs, de.rs_val, em, wb);
    assign rt_fwd = forward(de.rt, de.rt_val, em, wb);

    // writeback turns into bubbles during a freeze, so keep what it gave us
    assign op_a     = held ? rs_keep : rs_fwd;
    assign op_b_reg = held ? rt_keep : rt_fwd;
    assign op_b     = de.use_imm ? de.imm : op_b_reg;

    always_comb begin
        case (de.alu_op)
            pipe_pkg::ALU_ADD:    alu_out = op_a + op_b;
            pipe_pkg::ALU_SUB:    alu_out = op_a - op_b;
            pipe_pkg::ALU_AND:    alu_out = op_a & op_b;
            pipe_pkg::ALU_OR:     alu_out = op_a | op_b;
            pipe_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            pipe_pkg::ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            pipe_pkg::ALU_PASS_B: alu_out = op_b;
            default:              alu_out = '0;
        endcase
    end

    assign taken       = de.valid & de.branch & ((op_a == op_b_reg) ^ de.branch_ne);
    assign redirect    = taken & ~freeze;
    assign redirect_pc = de.pc + 32'd4 + {de.imm[29:0], 2'b00};

    always_comb begin
        em_next            = '0;
        em_next.valid      = de.valid;
        em_next.result     = alu_out;
        em_next.store_data = op_b_reg;
        em_next.dest       = de.dest;
        em_next.regwrite   = de.regwrite;
        em_next.memread    = de.memread;
        em_next.memwrite   = de.memwrite;
    end

    always_ff @(posedge clk) begin
        if (freeze && !held) begin
            rs_keep <= rs_fwd;
            rt_keep <= rt_fwd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            held     <= 1'b0;
            em.valid <= 1'b0;
        end else begin
            held <= freeze;
            if (!freeze) begin
                em <= em_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  isa_pkg::reg_addr_t rs_addr,
    input  isa_pkg::reg_addr_t rt_addr,
    output isa_pkg::word_t     rs_data,
    output isa_pkg::word_t     rt_data,
    input  pipe_pkg::wb_t      wb
);
    isa_pkg::word_t regs [32];
    logic           we;

    assign we = wb.valid & wb.regwrite & (wb.dest != '0);

    // r0 reads as zero, same-cycle write shows through
    assign rs_data = (rs_addr == '0) ? '0 :
                     (we && wb.dest == rs_addr) ? wb.data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (we && wb.dest == rt_addr) ? wb.data : regs[rt_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wb.dest] <= wb.data;
        end
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               hold_front,
    input  logic               flush_front,
    input  logic               freeze,
    input  pipe_pkg::fd_t      fd,
    output isa_pkg::reg_addr_t rs_addr,
    output isa_pkg::reg_addr_t rt_addr,
    input  isa_pkg::word_t     rs_data,
    input  isa_pkg::word_t     rt_data,
    output pipe_pkg::de_t      de
);
    isa_pkg::instr_u ins;
    isa_pkg::word_t  imm_sext;
    pipe_pkg::de_t   de_next;

    assign ins      = fd.instr;
    assign imm_sext = {{16{ins.i.imm[15]}}, ins.i.imm};

    // empty slot reads r0 and so never looks like a load-use match
    assign rs_addr = fd.valid ? ins.r.rs : '0;
    assign rt_addr = fd.valid ? ins.r.rt : '0;

    always_comb begin
        de_next        = '0;
        de_next.valid  = fd.valid & ~hold_front & ~flush_front;
        de_next.pc     = fd.pc;
        de_next.rs     = rs_addr;
        de_next.rt     = rt_addr;
        de_next.rs_val = rs_data;
        de_next.rt_val = rt_data;
        de_next.imm    = imm_sext;
        de_next.dest   = ins.i.rt;
        de_next.alu_op = pipe_pkg::ALU_ADD;
        case (ins.r.opcode)
            isa_pkg::OP_SPECIAL: begin
                de_next.dest     = ins.r.rd;
                de_next.regwrite = 1'b1;
                case (ins.r.funct)
                    isa_pkg::FN_ADDU: de_next.alu_op = pipe_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: de_next.alu_op = pipe_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  de_next.alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::FN_OR:   de_next.alu_op = pipe_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  de_next.alu_op = pipe_pkg::ALU_XOR;
                    isa_pkg::FN_SLT:  de_next.alu_op = pipe_pkg::ALU_SLT;
                    default:          de_next.regwrite = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDIU: begin
                de_next.regwrite = 1'b1;
                de_next.use_imm  = 1'b1;
            end
            isa_pkg::OP_ORI: begin
                de_next.regwrite = 1'b1;
                de_next.use_imm  = 1'b1;
                de_next.alu_op   = pipe_pkg::ALU_OR;
                de_next.imm      = {16'h0000, ins.i.imm};
            end
            isa_pkg::OP_LUI: begin
                de_next.regwrite = 1'b1;
                de_next.use_imm  = 1'b1;
                de_next.alu_op   = pipe_pkg::ALU_PASS_B;
                de_next.imm      = {ins.i.imm, 16'h0000};
            end
            isa_pkg::OP_LW: begin
                de_next.regwrite = 1'b1;
                de_next.memread  = 1'b1;
                de_next.use_imm  = 1'b1;
            end
            isa_pkg::OP_SW: begin
                de_next.memwrite = 1'b1;
                de_next.use_imm  = 1'b1;
            end
            isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
                de_next.branch    = 1'b1;
                de_next.branch_ne = (ins.i.opcode == isa_pkg::OP_BNE);
            end
            // anything else flows through as a no-op
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            de.valid <= 1'b0;
        end else if (!freeze) begin
            de <= de_next;
        end
    end

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
    parameter isa_pkg::word_t reset_pc = 32'hBFC0_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 hold_front,
    input  logic                 freeze,
    input  logic                 flush_front,
    input  logic                 redirect,
    input  isa_pkg::word_t       redirect_pc,
    output pipe_pkg::ibus_req_t  ibus_req,
    input  pipe_pkg::ibus_resp_t ibus_resp,
    output pipe_pkg::fd_t        fd
);
    isa_pkg::word_t pc;
    isa_pkg::word_t target;
    isa_pkg::word_t skid_pc;
    isa_pkg::word_t skid_instr;
    logic           req_valid;
    logic           drop;
    logic           skid_valid;
    logic           skid_next;
    logic           hold;
    logic           got;
    logic           keep;
    pipe_pkg::fd_t  fd_next;

    assign ibus_req.valid = req_valid;
    assign ibus_req.addr  = pc;

    assign hold = hold_front | freeze;
    assign got  = req_valid & ibus_resp.ok;
    // stale responses and the one racing a redirect are thrown away
    assign keep = got & ~drop & ~flush_front;

    always_comb begin
        if (flush_front) begin
            skid_next = 1'b0;
        end else if (hold && keep) begin
            skid_next = 1'b1;
        end else if (!hold) begin
            skid_next = 1'b0;
        end else begin
            skid_next = skid_valid;
        end
    end

    always_comb begin
        fd_next = fd;
        if (flush_front) begin
            fd_next.valid = 1'b0;
        end else if (!hold) begin
            if (skid_valid) begin
                fd_next.valid = 1'b1;
                fd_next.pc    = skid_pc;
                fd_next.instr = skid_instr;
            end else begin
                // bubble when nothing came back this cycle
                fd_next.valid = keep;
                fd_next.pc    = pc;
                fd_next.instr = ibus_resp.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hold && keep) begin
            skid_pc    <= pc;
            skid_instr <= ibus_resp.data;
        end
        if (reset) begin
            pc         <= reset_pc;
            req_valid  <= 1'b0;
            drop       <= 1'b0;
            skid_valid <= 1'b0;
            fd.valid   <= 1'b0;
        end else begin
            fd         <= fd_next;
            skid_valid <= skid_next;
            // no new request while the skid entry is occupied
            req_valid  <= (req_valid & ~got) | ~skid_next;
            if (redirect) begin
                if (req_valid && !got) begin
                    // address must stay put until ok, park the target
                    drop   <= 1'b1;
                    target <= redirect_pc;
                end else begin
                    pc   <= redirect_pc;
                    drop <= 1'b0;
                end
            end else if (got) begin
                pc   <= drop ? target : pc + 32'd4;
                drop <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    // instruction bus, valid held until ok
    typedef struct packed {
        logic           valid;
        isa_pkg::word_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic           ok;
        isa_pkg::word_t data;
    } ibus_resp_t;

    // data bus, word access only
    typedef struct packed {
        logic           valid;
        logic           write;
        isa_pkg::word_t addr;
        isa_pkg::word_t wdata;
    } dbus_req_t;

    typedef struct packed {
        logic           ok;
        isa_pkg::word_t rdata;
    } dbus_resp_t;

    typedef struct packed {
        logic           valid;
        isa_pkg::word_t pc;
        isa_pkg::word_t instr;
    } fd_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     pc;
        alu_op_t            alu_op;
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
        isa_pkg::word_t     rs_val;
        isa_pkg::word_t     rt_val;
        isa_pkg::word_t     imm;
        isa_pkg::reg_addr_t dest;
        logic               regwrite;
        logic               memread;
        logic               memwrite;
        logic               branch;
        logic               branch_ne;
        logic               use_imm;
    } de_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     result;
        isa_pkg::word_t     store_data;
        isa_pkg::reg_addr_t dest;
        logic               regwrite;
        logic               memread;
        logic               memwrite;
    } em_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     data;
        logic               regwrite;
    } wb_t;

endpackage

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // function codes under OP_SPECIAL
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    // one instruction word, two views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

`default_nettype wire
